// ==== hdl/ahbl_settings.svh ====
`ifndef AHBL_SETTINGS_SVH
`define AHBL_SETTINGS_SVH

// Number of masters on the arbiter
`define AHBL_N_PORTS 2

// Bus widths
`define AHBL_W_ADDR 32
`define AHBL_W_DATA 32

// SRAM size in 32-bit words
// Byte addresses at or above 4x this are out of range
`define AHBL_SRAM_DEPTH 256

// Wait states on every OKAY transfer
`define AHBL_SRAM_WAIT 1

`endif

// ==== hdl/ahbl_pkg.sv ====
`default_nettype none

`include "ahbl_settings.svh"

package ahbl_pkg;

	// HTRANS encodings
	// Bit 1 set means an active transfer
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// AHB-Lite has a single-bit HRESP
	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Address-phase signals from one master
	typedef struct packed {
		logic [`AHBL_W_ADDR-1:0] haddr;
		logic                    hwrite;
		htrans_e                 htrans;
		logic [2:0]              hsize;
		// Carried through only, no burst handling
		logic [2:0]              hburst;
		logic [3:0]              hprot;
		logic                    hmastlock;
	} ahbl_req_t;

	// Slave-to-master signals
	typedef struct packed {
		logic                    hready_resp;
		hresp_e                  hresp;
		logic [`AHBL_W_DATA-1:0] hrdata;
	} ahbl_resp_t;

endpackage

`default_nettype wire

// ==== hdl/sram_pkg.sv ====
`default_nettype none

`include "ahbl_settings.svh"

package sram_pkg;

	// Word index width into the array
	localparam int SRAM_W_IDX = $clog2(`AHBL_SRAM_DEPTH);

	// Slave FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_ERR1,
		ST_ERR2
	} sram_state_e;

	// Access captured at the address phase
	// Strobes are lane-zero aligned, shifted by lane at write time
	typedef struct packed {
		logic [SRAM_W_IDX-1:0] idx;
		logic                  write;
		logic [3:0]            strb;
		logic [1:0]            lane;
	} sram_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/bitmap_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

// AND-OR mux with a one-hot select
// Zero select gives a zero output
module bitmap_mux #(
	parameter int W_INPUT  = 32,
	parameter int N_INPUTS = 2
) (
	input  wire logic [N_INPUTS-1:0][W_INPUT-1:0] in,
	input  wire logic [N_INPUTS-1:0]              sel,
	output logic      [W_INPUT-1:0]               out
);

	always_comb begin
		out = '0;
		for (int i = 0; i < N_INPUTS; i++) begin
			// Mask each slice by its select bit
			out = out | (in[i] & {W_INPUT{sel[i]}});
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ahbl_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbl_settings.svh"

// Strict-priority N:1 AHB-Lite arbiter
// Port 0 has the highest priority
module ahbl_arbiter #(
	parameter int N_PORTS = `AHBL_N_PORTS
) (
	input  wire logic                                    clk,
	input  wire logic                                    rst_n,

	// Master side
	input  wire ahbl_pkg::ahbl_req_t [N_PORTS-1:0]       s_req,
	input  wire logic [N_PORTS-1:0][`AHBL_W_DATA-1:0]    s_hwdata,
	output ahbl_pkg::ahbl_resp_t [N_PORTS-1:0]           s_resp,

	// Bus hready, fed back from the slave
	input  wire logic                                    hready,

	// Slave side
	output ahbl_pkg::ahbl_req_t                          m_req,
	output logic [`AHBL_W_DATA-1:0]                      m_hwdata,
	input  wire ahbl_pkg::ahbl_resp_t                    m_resp
);

	import ahbl_pkg::*;

	// Address-phase requests and grant
	logic [N_PORTS-1:0] req_a;
	logic [N_PORTS-1:0] gnt_a;
	logic [N_PORTS-1:0] prio_gnt;
	logic               keep;

	// Data-phase owner
	logic [N_PORTS-1:0] gnt_d;

	// Active transfer when htrans is NONSEQ or SEQ
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			req_a[i] = s_req[i].htrans[1];
		end
	end

	// Lowest set bit of the request vector
	assign prio_gnt = req_a & (~req_a + N_PORTS'(1));

	// Data-phase owner keeps the bus if it asks again
	assign keep  = |(req_a & gnt_d);
	assign gnt_a = keep ? gnt_d : prio_gnt;

	// Owner moves only when the slave takes the address phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_d <= '0;
		end else if (hready) begin
			gnt_d <= gnt_a;
		end
	end

	// Address-phase bundle on the address grant
	// No requester selects nothing, so htrans reads IDLE
	bitmap_mux #(
		.W_INPUT  ($bits(ahbl_req_t)),
		.N_INPUTS (N_PORTS)
	) u_req_mux (
		.in  (s_req),
		.sel (gnt_a),
		.out (m_req)
	);

	// Write data follows the data-phase owner
	bitmap_mux #(
		.W_INPUT  (`AHBL_W_DATA),
		.N_INPUTS (N_PORTS)
	) u_hwdata_mux (
		.in  (s_hwdata),
		.sel (gnt_d),
		.out (m_hwdata)
	);

	// Response steering
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			// Stalled requesters see hready low until granted
			s_resp[i].hready_resp = m_resp.hready_resp & (~req_a[i] | gnt_a[i]);
			// Error goes only to the data-phase owner
			s_resp[i].hresp       = gnt_d[i] ? m_resp.hresp : OKAY;
			s_resp[i].hrdata      = m_resp.hrdata;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ahbl_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbl_settings.svh"

// AHB-Lite SRAM slave
module ahbl_sram (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire ahbl_pkg::ahbl_req_t     req,
	input  wire logic [`AHBL_W_DATA-1:0] hwdata,
	input  wire logic                    hready,
	output ahbl_pkg::ahbl_resp_t         resp
);

	import ahbl_pkg::*;
	import sram_pkg::*;

	localparam int W_CNT = $clog2(`AHBL_SRAM_WAIT + 2);
	localparam logic [`AHBL_W_ADDR-1:0] SRAM_BYTES = 4 * `AHBL_SRAM_DEPTH;

	logic [`AHBL_W_DATA-1:0] mem [`AHBL_SRAM_DEPTH];

	sram_state_e      state;
	sram_state_e      state_nxt;
	sram_cmd_t        cmd;
	sram_cmd_t        cmd_nxt;
	logic [W_CNT-1:0] cnt;
	logic             accept;
	logic             in_range;
	logic             last;
	logic [3:0]       size_mask;
	logic [3:0]       wr_strb;

	assign accept   = hready & req.htrans[1];
	assign in_range = req.haddr < SRAM_BYTES;
	// Final data-phase cycle of an OKAY transfer
	assign last     = (state == ST_WAIT) && (cnt == '0);
	assign wr_strb  = cmd.strb << cmd.lane;

	// Byte, halfword, word
	always_comb begin
		case (req.hsize)
			3'd0:    size_mask = 4'b0001;
			3'd1:    size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
		cmd_nxt.idx   = req.haddr[SRAM_W_IDX+1:2];
		cmd_nxt.write = req.hwrite;
		cmd_nxt.strb  = size_mask;
		cmd_nxt.lane  = req.haddr[1:0];
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WAIT: if (cnt == '0) state_nxt = ST_IDLE;
			ST_ERR1: state_nxt = ST_ERR2;
			default: state_nxt = ST_IDLE;
		endcase
		// New address phase overrides when hready is high
		if (accept)
			state_nxt = in_range ? ST_WAIT : ST_ERR1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			state <= state_nxt;
			if (accept && in_range)
				cnt <= W_CNT'(`AHBL_SRAM_WAIT);
			else if (state == ST_WAIT && cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	// Command capture and byte-lane write merge
	always_ff @(posedge clk) begin
		if (accept)
			cmd <= cmd_nxt;
		if (last && hready && cmd.write) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_strb[b])
					mem[cmd.idx][8*b +: 8] <= hwdata[8*b +: 8];
			end
		end
	end

	// Whole word on reads, two-cycle error
	always_comb begin
		resp.hrdata = mem[cmd.idx];
		case (state)
			ST_WAIT: begin
				resp.hready_resp = last;
				resp.hresp       = OKAY;
			end
			ST_ERR1: begin
				resp.hready_resp = 1'b0;
				resp.hresp       = ERROR;
			end
			ST_ERR2: begin
				resp.hready_resp = 1'b1;
				resp.hresp       = ERROR;
			end
			default: begin
				resp.hready_resp = 1'b1;
				resp.hresp       = OKAY;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/ahbl_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbl_settings.svh"

// Two masters sharing one SRAM slave
module ahbl_subsystem (
	input  wire logic                                       clk,
	input  wire logic                                       rst_n,
	input  wire ahbl_pkg::ahbl_req_t [`AHBL_N_PORTS-1:0]    s_req,
	input  wire logic [`AHBL_N_PORTS-1:0][`AHBL_W_DATA-1:0] s_hwdata,
	output ahbl_pkg::ahbl_resp_t [`AHBL_N_PORTS-1:0]        s_resp
);

	import ahbl_pkg::*;

	// Arbiter to slave
	ahbl_req_t               m_req;
	logic [`AHBL_W_DATA-1:0] m_hwdata;
	ahbl_resp_t              m_resp;

	// Single slave, so its hready_resp is the bus hready
	logic hready;

	assign hready = m_resp.hready_resp;

	ahbl_arbiter #(
		.N_PORTS (`AHBL_N_PORTS)
	) u_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.s_req    (s_req),
		.s_hwdata (s_hwdata),
		.s_resp   (s_resp),
		.hready   (hready),
		.m_req    (m_req),
		.m_hwdata (m_hwdata),
		.m_resp   (m_resp)
	);

	ahbl_sram u_sram (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (m_req),
		.hwdata (m_hwdata),
		.hready (hready),
		.resp   (m_resp)
	);

endmodule

`default_nettype wire

// ==== tb/ahbl_arbiter_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// Grant and response rules of the AHB-Lite arbiter
module ahbl_arbiter_sva #(
	parameter int N_PORTS = 2
) (
	input  wire logic                                  clk,
	input  wire logic                                  rst_n,
	input  wire logic                                  hready,
	input  wire logic [N_PORTS-1:0]                    req_a,
	input  wire logic [N_PORTS-1:0]                    gnt_a,
	input  wire ahbl_pkg::ahbl_req_t [N_PORTS-1:0]     s_req,
	input  wire ahbl_pkg::ahbl_resp_t [N_PORTS-1:0]    s_resp,
	input  wire ahbl_pkg::ahbl_req_t                   m_req
);

	// At most one master owns the address phase
	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_a))
		else $error("Address grant %b is not one-hot or zero", gnt_a);

	for (genvar i = 0; i < N_PORTS; i++) begin : g_port
		// Stalled granted request stays put
		hold_req: assert property (@(posedge clk) disable iff (!rst_n)
			(req_a[i] && gnt_a[i] && !hready) |=> $stable(s_req[i]))
			else $error("Port %0d changed its request while stalled", i);

		// Losing requester is held off
		// Not granted when the slave sees some other request
		lose_stall: assert property (@(posedge clk) disable iff (!rst_n)
			(req_a[i] && (m_req != s_req[i])) |-> !s_resp[i].hready_resp)
			else $error("Port %0d not granted but sees hready_resp high", i);
	end

endmodule

`default_nettype wire

// ==== tb/tb_ahbl_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbl_settings.svh"

module tb_ahbl_subsystem;

	import ahbl_pkg::*;

	localparam int N_T2 = 16;
	localparam int N_T6 = 200;
	// Transfers over tests 2 to 6
	localparam int N_XFERS     = 2 * N_T2 + 13 + 4 + 4 + 16 + 2 * N_T6;
	localparam int CYCLE_LIMIT = 20 * N_XFERS * (`AHBL_SRAM_WAIT + 3);
	localparam logic [31:0] RANGE_BYTES = 4 * `AHBL_SRAM_DEPTH;

	logic clk;
	logic rst_n;
	ahbl_req_t  [`AHBL_N_PORTS-1:0]                   s_req;
	logic       [`AHBL_N_PORTS-1:0][`AHBL_W_DATA-1:0] s_hwdata;
	ahbl_resp_t [`AHBL_N_PORTS-1:0]                   s_resp;

	// Reference memory, updated in acceptance order
	logic [31:0] ref_mem [`AHBL_SRAM_DEPTH];

	int seed      = 32'h9524;
	int checks    = 0;
	int errors    = 0;
	int cycle_cnt = 0;

	ahbl_subsystem DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.s_req    (s_req),
		.s_hwdata (s_hwdata),
		.s_resp   (s_resp)
	);

	bind ahbl_arbiter ahbl_arbiter_sva #(
		.N_PORTS (N_PORTS)
	) u_arbiter_sva (
		.clk    (clk),
		.rst_n  (rst_n),
		.hready (hready),
		.req_a  (req_a),
		.gnt_a  (gnt_a),
		.s_req  (s_req),
		.s_resp (s_resp),
		.m_req  (m_req)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Run limit from the transfer count
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	// New word after a write of 1 << size bytes starting at lane ofs
	function automatic logic [31:0] merge_lanes(input logic [31:0] old,
			input logic [31:0] wdata, input logic [1:0] ofs, input logic [2:0] size);
		logic [31:0] res;
		int          nbytes;
		res    = old;
		nbytes = 1 << size;
		for (int b = 0; b < 4; b++) begin
			if (b >= ofs && b < ofs + nbytes)
				res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		$display("Test %0d %s: %0d errors", num, name, errors - mark);
	endtask

	// One single transfer from port p, started and ended 1 ns after an edge
	task automatic run_xfer(input int p, input logic wr, input logic [31:0] addr,
			input logic [2:0] size, output int cycles);
		logic [31:0] wdata;
		logic [31:0] exp;
		logic        bad;
		logic        rdy_1st;
		logic        err_1st;
		wdata   = $random(seed);
		bad     = addr >= RANGE_BYTES;
		exp     = '0;
		rdy_1st = 1'b0;
		err_1st = 1'b0;
		s_req[p] = '{haddr: addr, hwrite: wr, htrans: NONSEQ, hsize: size,
			hburst: 3'b000, hprot: 4'b0011, hmastlock: 1'b0};
		// Address phase, held until own hready_resp is high
		@(posedge clk);
		while (!s_resp[p].hready_resp)
			@(posedge clk);
		// Accepted here
		if (!bad) begin
			exp = ref_mem[addr / 4];
			if (wr)
				ref_mem[addr / 4] = merge_lanes(exp, wdata, addr[1:0], size);
		end
		#1;
		s_req[p].htrans = IDLE;
		s_hwdata[p]     = wdata;
		// Not requesting now, so own hready_resp is the bus hready
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles == 1) begin
				rdy_1st = s_resp[p].hready_resp;
				err_1st = s_resp[p].hresp;
			end
		end while (!s_resp[p].hready_resp);
		if (bad) begin
			check_value($sformatf("port %0d error cycles at %h", p, addr), cycles, 2);
			check_value($sformatf("port %0d ERR1 hready at %h", p, addr), rdy_1st, 1'b0);
			check_value($sformatf("port %0d ERR1 hresp at %h", p, addr), err_1st, ERROR);
			check_value($sformatf("port %0d ERR2 hresp at %h", p, addr),
				s_resp[p].hresp, ERROR);
		end else begin
			check_value($sformatf("port %0d hresp at %h", p, addr), s_resp[p].hresp, OKAY);
			if (!wr)
				check_value($sformatf("port %0d read at %h", p, addr),
					s_resp[p].hrdata, exp);
		end
		#1;
	endtask

	// Mixed traffic over 16 words at 0x200
	task automatic random_traffic(input int p, input int n);
		logic [31:0] r;
		logic [31:0] addr;
		logic [2:0]  size;
		int          cyc;
		for (int k = 0; k < n; k++) begin
			r    = $random(seed);
			addr = 32'h200 + {r[7:4], 2'b00};
			size = 3'd2;
			// Writes of any size, reads are whole words
			if (r[10] && r[1:0] != 2'd3)
				size = {1'b0, r[1:0]};
			if (size == 3'd0)
				addr[1:0] = r[9:8];
			else if (size == 3'd1)
				addr[1] = r[9];
			// Idle gap now and then
			if (r[12]) begin
				repeat (1 + r[11]) @(posedge clk);
				#1;
			end
			run_xfer(p, r[10], addr, size, cyc);
		end
	endtask

	initial begin
		int cyc;
		int cyc_a;
		int cyc_b;
		int mark;
		rst_n    = 1'b0;
		s_req    = '0;
		s_hwdata = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle bus straight out of reset
		mark = errors;
		@(posedge clk);
		for (int p = 0; p < `AHBL_N_PORTS; p++) begin
			check_value($sformatf("port %0d hready_resp after reset", p),
				s_resp[p].hready_resp, 1'b1);
			check_value($sformatf("port %0d hresp after reset", p), s_resp[p].hresp, OKAY);
		end
		#1;
		report_test(1, "reset state", mark);

		// Master 0 alone
		mark = errors;
		for (int k = 0; k < N_T2; k++)
			run_xfer(0, 1'b1, 4 * k, 3'd2, cyc);
		for (int k = 0; k < N_T2; k++) begin
			run_xfer(0, 1'b0, 4 * k, 3'd2, cyc);
			checks++;
			assert (cyc <= `AHBL_SRAM_WAIT + 1) else begin
				errors++;
				$display("Error at %0t ns: read of %h took %0d data-phase cycles",
					$time, 4 * k, cyc);
			end
		end
		report_test(2, "word write and read", mark);

		// Each byte lane, then both halfwords
		mark = errors;
		run_xfer(0, 1'b1, 32'h80, 3'd2, cyc);
		for (int b = 0; b < 4; b++) begin
			run_xfer(0, 1'b1, 32'h80 + b, 3'd0, cyc);
			run_xfer(0, 1'b0, 32'h80, 3'd2, cyc);
		end
		for (int h = 0; h < 4; h += 2) begin
			run_xfer(0, 1'b1, 32'h80 + h, 3'd1, cyc);
			run_xfer(0, 1'b0, 32'h80, 3'd2, cyc);
		end
		report_test(3, "byte and halfword lanes", mark);

		// Same-cycle requests, no data-phase owner
		mark = errors;
		repeat (2) @(posedge clk);
		#1;
		fork
			run_xfer(0, 1'b1, 32'h100, 3'd2, cyc_a);
			run_xfer(1, 1'b0, 32'h100, 3'd2, cyc_b);
			begin
				@(posedge clk);
				check_value("port 0 hready_resp on contention", s_resp[0].hready_resp, 1'b1);
				check_value("port 1 hready_resp on contention", s_resp[1].hready_resp, 1'b0);
			end
		join
		// Master 0 reads before master 1 writes
		fork
			run_xfer(0, 1'b0, 32'h10, 3'd2, cyc_a);
			run_xfer(1, 1'b1, 32'h10, 3'd2, cyc_b);
		join
		report_test(4, "two-master contention", mark);

		// Out of range aliases words 3 and 4
		mark = errors;
		for (int p = 0; p < `AHBL_N_PORTS; p++) begin
			run_xfer(p, 1'b1, RANGE_BYTES + 4 * (p + 3), 3'd2, cyc);
			run_xfer(p, 1'b0, 4 * (p + 3), 3'd2, cyc);
		end
		report_test(5, "range error", mark);

		// Known contents first
		mark = errors;
		for (int k = 0; k < 16; k++)
			run_xfer(0, 1'b1, 32'h200 + 4 * k, 3'd2, cyc);
		fork
			random_traffic(0, N_T6);
			random_traffic(1, N_T6);
		join
		report_test(6, "random two-master traffic", mark);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/ahbl_pkg.sv
hdl/sram_pkg.sv
hdl/bitmap_mux.sv
hdl/ahbl_arbiter.sv
hdl/ahbl_sram.sv
hdl/ahbl_subsystem.sv
tb/ahbl_arbiter_sva.sv
tb/tb_ahbl_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_ahbl_subsystem
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

# A crash without a verdict counts as a failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "*** FAILED ***" >> $(LOG)
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
